//--- source/lbm_pkg.sv
package lbm_pkg;

    ////////////////////////////////////////
    // grid geometry
    ////////////////////////////////////////

    localparam int GRID_WIDTH  = 8;
    localparam int GRID_HEIGHT = 8;
    // cells in the whole grid
    localparam int GRID_DEPTH  = GRID_WIDTH * GRID_HEIGHT;
    localparam int ADDR_WIDTH  = $clog2(GRID_DEPTH);
    localparam int COL_WIDTH   = $clog2(GRID_WIDTH);
    // one distribution value
    localparam int DATA_WIDTH  = 16;
    localparam int NUM_DIRS    = 9;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [COL_WIDTH-1:0]  col_t;
    typedef logic [DATA_WIDTH-1:0] word_t;

    ////////////////////////////////////////
    // velocity directions
    ////////////////////////////////////////

    // d2q9 order, rest first then clockwise from north
    typedef enum logic [3:0] {
        DIR_REST = 4'd0,
        DIR_N    = 4'd1,
        DIR_NE   = 4'd2,
        DIR_E    = 4'd3,
        DIR_SE   = 4'd4,
        DIR_S    = 4'd5,
        DIR_SW   = 4'd6,
        DIR_W    = 4'd7,
        DIR_NW   = 4'd8
    } dir_t;

    // column step, east is +1
    localparam int DIR_DX [NUM_DIRS] = '{0, 0, 1, 1, 1, 0, -1, -1, -1};
    // row step, north is one row lower in index
    localparam int DIR_DY [NUM_DIRS] = '{0, -1, -1, 0, 1, 1, 1, 0, -1};

    // reflection partner, rest maps to itself
    localparam dir_t OPPOSITE_DIR [NUM_DIRS] = '{
        DIR_REST, DIR_S, DIR_SW, DIR_W, DIR_NW, DIR_N, DIR_NE, DIR_E, DIR_SE
    };

    ////////////////////////////////////////
    // sweep phases
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        PH_IDLE         = 3'd0,
        PH_STREAM       = 3'd1,
        // one extra cycle for the last stream write
        PH_STREAM_DRAIN = 3'd2,
        PH_BOUNCE       = 3'd3,
        // barrier read returns here
        PH_BOUNCE_WAIT  = 3'd4,
        PH_ZERO         = 3'd5,
        PH_DONE         = 3'd6
    } phase_t;

endpackage

//--- source/lbm_sweep_sequencer.sv
`timescale 1ns/1ps

module lbm_sweep_sequencer (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           start,
    input  logic [lbm_pkg::GRID_DEPTH-1:0] barriers,
    output lbm_pkg::phase_t                phase,
    output lbm_pkg::addr_t                 cell_index,
    output logic                           stream_rd,
    output logic                           bounce_rd,
    output lbm_pkg::addr_t                 wr_index,
    output lbm_pkg::col_t                  wr_col,
    output logic                           stream_wr,
    output logic                           bounce_wr,
    output logic                           zero_wr,
    output logic                           busy,
    output logic                           done
);

    import lbm_pkg::*;

    // column of cell_index, kept alongside it
    col_t   col;
    phase_t phase_next;
    logic   advance;
    logic   is_barrier;
    logic   last_cell;

    // only place the barrier mask is looked at
    assign is_barrier = barriers[cell_index];
    assign last_cell  = (cell_index == addr_t'(GRID_DEPTH - 1));

    ////////////////////////////////////////
    // phase machine
    ////////////////////////////////////////

    always_comb
    begin
        phase_next = phase;
        advance    = 1'b0;
        case (phase)
            PH_IDLE:
            begin
                if (start)
                    phase_next = PH_STREAM;
            end
            PH_STREAM:
            begin
                advance = 1'b1;
                if (last_cell)
                    phase_next = PH_STREAM_DRAIN;
            end
            PH_STREAM_DRAIN:
            begin
                phase_next = PH_BOUNCE;
            end
            PH_BOUNCE:
            begin
                // barrier cell needs a read first
                if (is_barrier)
                    phase_next = PH_BOUNCE_WAIT;
                else
                begin
                    advance = 1'b1;
                    if (last_cell)
                        phase_next = PH_ZERO;
                end
            end
            PH_BOUNCE_WAIT:
            begin
                advance    = 1'b1;
                phase_next = last_cell ? PH_ZERO : PH_BOUNCE;
            end
            PH_ZERO:
            begin
                advance = 1'b1;
                if (last_cell)
                    phase_next = PH_DONE;
            end
            PH_DONE:
            begin
                phase_next = PH_IDLE;
            end
            default:
            begin
                phase_next = PH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            phase      <= PH_IDLE;
            cell_index <= '0;
            col        <= '0;
        end
        else
        begin
            phase <= phase_next;
            // every pass starts again at cell 0
            if (advance)
            begin
                if (last_cell)
                begin
                    cell_index <= '0;
                    col        <= '0;
                end
                else
                begin
                    cell_index <= cell_index + addr_t'(1);
                    col        <= (col == col_t'(GRID_WIDTH - 1)) ? '0 : col + col_t'(1);
                end
            end
        end
    end

    ////////////////////////////////////////
    // read strobes and write stage
    ////////////////////////////////////////

    assign stream_rd = (phase == PH_STREAM) && !is_barrier;
    assign bounce_rd = (phase == PH_BOUNCE) && is_barrier;
    // zero pass needs no read, writes in place
    assign zero_wr   = (phase == PH_ZERO) && is_barrier;

    // write stage trails the read by one cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_index  <= '0;
            wr_col    <= '0;
            stream_wr <= 1'b0;
            bounce_wr <= 1'b0;
        end
        else
        begin
            wr_index  <= cell_index;
            wr_col    <= col;
            stream_wr <= stream_rd;
            bounce_wr <= bounce_rd;
        end
    end

    assign busy = (phase != PH_IDLE) && (phase != PH_DONE);
    assign done = (phase == PH_DONE);

endmodule

//--- source/lbm_direction_lane.sv
`timescale 1ns/1ps

module lbm_direction_lane #(
    parameter lbm_pkg::dir_t DIR = lbm_pkg::DIR_REST
) (
    input  logic           clk,
    input  lbm_pkg::addr_t cell_index,
    input  lbm_pkg::addr_t wr_index,
    input  lbm_pkg::col_t  wr_col,
    input  logic           stream_rd,
    input  logic           bounce_rd,
    input  logic           stream_wr,
    input  logic           bounce_wr,
    input  logic           zero_wr,
    input  logic           busy,
    input  logic           load_en,
    input  lbm_pkg::dir_t  load_dir,
    input  lbm_pkg::addr_t load_addr,
    input  lbm_pkg::word_t load_data,
    input  lbm_pkg::addr_t rd_addr,
    input  lbm_pkg::word_t bounce_data,
    output lbm_pkg::word_t next_q
);

    import lbm_pkg::*;

    localparam int DX     = DIR_DX[DIR];
    localparam int DY     = DIR_DY[DIR];
    // rest lane takes no part in bounce
    localparam bit MOVING = (DIR != DIR_REST);

    word_t cur_bank  [GRID_DEPTH];
    word_t next_bank [GRID_DEPTH];
    word_t cur_q;

    logic  load_hit;
    int    nb_col;
    int    nb_row;
    logic  nb_on_grid;
    addr_t nb_addr;
    logic  next_we;
    addr_t next_waddr;
    word_t next_wdata;
    logic  next_re;
    addr_t next_raddr;

    assign load_hit = load_en && !busy && (load_dir == DIR);

    ////////////////////////////////////////
    // neighbor of the write-stage cell
    ////////////////////////////////////////

    always_comb
    begin
        nb_col     = int'(wr_col) + DX;
        nb_row     = int'(wr_index) / GRID_WIDTH + DY;
        // no wrap, off-grid writes are dropped
        nb_on_grid = (nb_col >= 0) && (nb_col < GRID_WIDTH)
                     && (nb_row >= 0) && (nb_row < GRID_HEIGHT);
        nb_addr    = addr_t'(nb_row * GRID_WIDTH + nb_col);
    end

    // current bank, loads only, read in stream pass
    always_ff @(posedge clk)
    begin
        if (load_hit)
            cur_bank[load_addr] <= load_data;
        if (stream_rd)
            cur_q <= cur_bank[cell_index];
    end

    ////////////////////////////////////////
    // next bank port select
    ////////////////////////////////////////

    always_comb
    begin
        next_we    = 1'b0;
        next_waddr = nb_addr;
        next_wdata = cur_q;
        if (load_hit)
        begin
            next_we    = 1'b1;
            next_waddr = load_addr;
            next_wdata = load_data;
        end
        else if (stream_wr)
        begin
            next_we = nb_on_grid;
        end
        else if (bounce_wr && MOVING)
        begin
            // opposite lane word read at the barrier cell
            next_we    = nb_on_grid;
            next_wdata = bounce_data;
        end
        else if (zero_wr)
        begin
            next_we    = 1'b1;
            next_waddr = cell_index;
            next_wdata = '0;
        end
    end

    // sweep reads for bounce, idle reads follow the readout address
    assign next_re    = busy ? bounce_rd : 1'b1;
    assign next_raddr = busy ? cell_index : rd_addr;

    // held read word stays valid through bounce_wait
    always_ff @(posedge clk)
    begin
        if (next_we)
            next_bank[next_waddr] <= next_wdata;
        if (next_re)
            next_q <= next_bank[next_raddr];
    end

endmodule

//--- source/lbm_readout.sv
`timescale 1ns/1ps

module lbm_readout (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           rd_en,
    input  lbm_pkg::dir_t  rd_dir,
    input  logic           busy,
    input  lbm_pkg::word_t lane_q [lbm_pkg::NUM_DIRS],
    output lbm_pkg::word_t rd_data,
    output logic           rd_valid
);

    import lbm_pkg::*;

    // lane select, one cycle behind like the bank read
    dir_t dir_q;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_valid <= 1'b0;
            dir_q    <= DIR_REST;
        end
        else
        begin
            // reads dropped during a sweep
            rd_valid <= rd_en && !busy;
            if (rd_en)
                dir_q <= rd_dir;
        end
    end

    always_comb
    begin
        rd_data = '0;
        // codes past nw select nothing
        if (int'(dir_q) < NUM_DIRS)
            rd_data = lane_q[dir_q];
    end

endmodule

//--- source/lbm_stream_core.sv
`timescale 1ns/1ps

module lbm_stream_core (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           start,
    input  logic [lbm_pkg::GRID_DEPTH-1:0] barriers,
    input  logic                           load_en,
    input  lbm_pkg::dir_t                  load_dir,
    input  lbm_pkg::addr_t                 load_addr,
    input  lbm_pkg::word_t                 load_data,
    input  logic                           rd_en,
    input  lbm_pkg::dir_t                  rd_dir,
    input  lbm_pkg::addr_t                 rd_addr,
    output lbm_pkg::word_t                 rd_data,
    output logic                           rd_valid,
    output logic                           busy,
    output logic                           done
);

    import lbm_pkg::*;

    addr_t cell_index;
    addr_t wr_index;
    col_t  wr_col;
    logic  stream_rd;
    logic  bounce_rd;
    logic  stream_wr;
    logic  bounce_wr;
    logic  zero_wr;
    // next-bank read word of every lane
    word_t lane_q [NUM_DIRS];

    ////////////////////////////////////////
    // sweep control
    ////////////////////////////////////////

    // phase left open, for observation only
    lbm_sweep_sequencer u_lbm_sweep_sequencer (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .barriers   (barriers),
        .phase      (),
        .cell_index (cell_index),
        .stream_rd  (stream_rd),
        .bounce_rd  (bounce_rd),
        .wr_index   (wr_index),
        .wr_col     (wr_col),
        .stream_wr  (stream_wr),
        .bounce_wr  (bounce_wr),
        .zero_wr    (zero_wr),
        .busy       (busy),
        .done       (done)
    );

    ////////////////////////////////////////
    // nine direction lanes
    ////////////////////////////////////////

    for (genvar d = 0; d < NUM_DIRS; d++)
    begin : g_lane
        // bounce source is the opposite lane at the same cell
        lbm_direction_lane #(
            .DIR (dir_t'(d))
        ) u_lbm_direction_lane (
            .clk         (clk),
            .cell_index  (cell_index),
            .wr_index    (wr_index),
            .wr_col      (wr_col),
            .stream_rd   (stream_rd),
            .bounce_rd   (bounce_rd),
            .stream_wr   (stream_wr),
            .bounce_wr   (bounce_wr),
            .zero_wr     (zero_wr),
            .busy        (busy),
            .load_en     (load_en),
            .load_dir    (load_dir),
            .load_addr   (load_addr),
            .load_data   (load_data),
            .rd_addr     (rd_addr),
            .bounce_data (lane_q[OPPOSITE_DIR[d]]),
            .next_q      (lane_q[d])
        );
    end

    lbm_readout u_lbm_readout (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_en    (rd_en),
        .rd_dir   (rd_dir),
        .busy     (busy),
        .lane_q   (lane_q),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

endmodule

//--- tests/lbm_sweep_props.sv
`timescale 1ns/1ps

module lbm_sweep_props (
    input logic clk,
    input logic arst_n,
    input logic busy,
    input logic done,
    input logic stream_wr,
    input logic bounce_wr,
    input logic zero_wr
);

    // failed assertion count, read by the testbench at the end
    int assert_errors = 0;

    // done is a single-cycle pulse
    done_single_pulse: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
    else
    begin
        $error("done stayed high for more than one cycle");
        assert_errors++;
    end

    // write stage only active inside a sweep
    write_needs_busy: assert property (@(posedge clk) disable iff (!arst_n)
        (stream_wr || bounce_wr || zero_wr) |-> busy)
    else
    begin
        $error("write strobe fired while the engine was idle");
        assert_errors++;
    end

    // stream and zero passes never overlap
    stream_zero_apart: assert property (@(posedge clk) disable iff (!arst_n)
        !(stream_wr && zero_wr))
    else
    begin
        $error("stream_wr and zero_wr fired in the same cycle");
        assert_errors++;
    end

endmodule

//--- tests/lbm_checker.sv
`timescale 1ns/1ps

module lbm_checker (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           start,
    input  logic [lbm_pkg::GRID_DEPTH-1:0] barriers,
    input  logic                           load_en,
    input  lbm_pkg::dir_t                  load_dir,
    input  lbm_pkg::addr_t                 load_addr,
    input  lbm_pkg::word_t                 load_data,
    input  logic                           rd_en,
    input  lbm_pkg::dir_t                  rd_dir,
    input  lbm_pkg::addr_t                 rd_addr,
    input  lbm_pkg::word_t                 rd_data,
    input  logic                           rd_valid,
    input  logic                           busy,
    input  logic                           done,
    input  int                             exp_busy,
    output int                             errors,
    output int                             checks
);

    import lbm_pkg::*;

    // model of both banks, every lane
    word_t cur_m  [NUM_DIRS][GRID_DEPTH];
    word_t next_m [NUM_DIRS][GRID_DEPTH];
    word_t exp_word;
    logic  exp_valid = 1'b0;
    // sweep cycles still to run, zero when idle
    int    busy_left = 0;
    logic  done_m    = 1'b0;
    logic  busy_m;

    assign busy_m = (busy_left > 0);

    initial
    begin
        errors = 0;
        checks = 0;
    end

    // neighbor index, -1 when off the grid
    function automatic int neighbor(input int idx, input int d);
        int col;
        int row;
        col = idx % GRID_WIDTH + DIR_DX[d];
        row = idx / GRID_WIDTH + DIR_DY[d];
        if (col < 0 || col >= GRID_WIDTH || row < 0 || row >= GRID_HEIGHT)
            return -1;
        return row * GRID_WIDTH + col;
    endfunction

    ////////////////////////////////////////
    // one sweep, three passes in index order
    ////////////////////////////////////////

    task automatic apply_sweep();
        word_t held [NUM_DIRS];
        int    nb;
        // stream, fluid cells only
        for (int i = 0; i < GRID_DEPTH; i++)
        begin
            if (!barriers[i])
            begin
                for (int d = 0; d < NUM_DIRS; d++)
                begin
                    nb = neighbor(i, d);
                    if (nb >= 0)
                        next_m[d][nb] = cur_m[d][i];
                end
            end
        end
        // bounce, all lanes read at i before any write
        for (int i = 0; i < GRID_DEPTH; i++)
        begin
            if (barriers[i])
            begin
                for (int d = 0; d < NUM_DIRS; d++)
                    held[d] = next_m[d][i];
                for (int d = 1; d < NUM_DIRS; d++)
                begin
                    nb = neighbor(i, d);
                    if (nb >= 0)
                        next_m[d][nb] = held[OPPOSITE_DIR[d]];
                end
            end
        end
        // zero, barrier cells cleared in place
        for (int i = 0; i < GRID_DEPTH; i++)
        begin
            if (barriers[i])
            begin
                for (int d = 0; d < NUM_DIRS; d++)
                    next_m[d][i] = '0;
            end
        end
    endtask

    // sweep timing, start taken only while idle
    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy_left <= 0;
            done_m    <= 1'b0;
        end
        else
        begin
            // done in the cycle after the last busy one
            done_m <= (busy_left == 1);
            if (busy_left > 0)
                busy_left <= busy_left - 1;
            else if (start && !done_m)
                busy_left <= exp_busy;
        end
    end

    // inputs are stable at the rising edge
    always @(posedge clk)
    begin
        exp_valid <= rd_en && !busy_m;
        if (rd_en && !busy_m)
            exp_word <= next_m[rd_dir][rd_addr];
        // loads land in both banks, dropped while busy
        if (load_en && !busy_m)
        begin
            cur_m[load_dir][load_addr]  = load_data;
            next_m[load_dir][load_addr] = load_data;
        end
    end

    ////////////////////////////////////////
    // outputs compared mid-cycle
    ////////////////////////////////////////

    always @(negedge clk)
    begin
        if (arst_n)
        begin
            if (busy !== busy_m)
            begin
                $display("mismatch %0t busy expected %b actual %b",
                         $time, busy_m, busy);
                errors++;
            end
            if (done !== done_m)
            begin
                $display("mismatch %0t done expected %b actual %b",
                         $time, done_m, done);
                errors++;
            end
            if (rd_valid !== exp_valid)
            begin
                $display("mismatch %0t rd_valid expected %b actual %b",
                         $time, exp_valid, rd_valid);
                errors++;
            end
            else if (exp_valid)
            begin
                checks++;
                if (rd_data !== exp_word)
                begin
                    $display("mismatch %0t rd_data expected %h actual %h",
                             $time, exp_word, rd_data);
                    errors++;
                end
            end
            // sweep over, next bank moves on
            if (done_m)
            begin
                checks++;
                apply_sweep();
            end
        end
    end

endmodule

//--- tests/lbm_tb.sv
`timescale 1ns/1ps

module lbm_tb;

    import lbm_pkg::*;

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 4;
    localparam int WORDS        = GRID_DEPTH * NUM_DIRS;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  start;
    logic [GRID_DEPTH-1:0] barriers;
    logic                  load_en;
    dir_t                  load_dir;
    addr_t                 load_addr;
    word_t                 load_data;
    logic                  rd_en;
    dir_t                  rd_dir;
    addr_t                 rd_addr;
    word_t                 rd_data;
    logic                  rd_valid;
    logic                  busy;
    logic                  done;
    int                    exp_busy;
    int                    errors;
    int                    checks;
    int                    cycle_count = 0;
    int                    cycle_limit = 0;
    logic [31:0]           lfsr_state  = 32'hd2571016;

    ////////////////////////////////////////
    // test table
    ////////////////////////////////////////

    string                 test_name   [NUM_TESTS] = '{
        "open_grid", "single_barrier", "edge_barriers", "dense_mix"
    };
    logic [GRID_DEPTH-1:0] test_mask   [NUM_TESTS] = '{
        64'h0, 64'h0000_0000_1000_0000, 64'h8100_0000_0000_00ff, 64'h0f0f_3c3c_a5a5_0ff0
    };
    int                    test_sweeps [NUM_TESTS] = '{1, 1, 2, 2};
    // 3 passes of 64 plus drain plus one per barrier
    int                    test_busy   [NUM_TESTS] = '{193, 194, 203, 225};

    lbm_stream_core u_lbm_stream_core (
        .clk (clk), .arst_n (arst_n), .start (start), .barriers (barriers),
        .load_en (load_en), .load_dir (load_dir), .load_addr (load_addr),
        .load_data (load_data), .rd_en (rd_en), .rd_dir (rd_dir), .rd_addr (rd_addr),
        .rd_data (rd_data), .rd_valid (rd_valid), .busy (busy), .done (done)
    );

    lbm_checker u_lbm_checker (
        .clk (clk), .arst_n (arst_n), .start (start), .barriers (barriers),
        .load_en (load_en), .load_dir (load_dir), .load_addr (load_addr),
        .load_data (load_data), .rd_en (rd_en), .rd_dir (rd_dir), .rd_addr (rd_addr),
        .rd_data (rd_data), .rd_valid (rd_valid), .busy (busy), .done (done),
        .exp_busy (exp_busy), .errors (errors), .checks (checks)
    );

    bind lbm_sweep_sequencer lbm_sweep_props u_lbm_sweep_props (
        .clk (clk), .arst_n (arst_n), .busy (busy), .done (done),
        .stream_wr (stream_wr), .bounce_wr (bounce_wr), .zero_wr (zero_wr)
    );

    always #(CLK_HALF) clk = ~clk;

    // galois step, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic random_word(output word_t w);
        for (int b = 0; b < DATA_WIDTH; b++)
        begin
            w          = {w[DATA_WIDTH-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // upper bound, twice the expected run
    function automatic int run_limit();
        int total;
        total = RESET_CYCLES;
        for (int t = 0; t < NUM_TESTS; t++)
            total += 2 * (WORDS + 2) + test_sweeps[t] * (test_busy[t] + 12 + WORDS);
        return 2 * total;
    endfunction

    task automatic load_grid();
        word_t w;
        for (int d = 0; d < NUM_DIRS; d++)
        begin
            for (int a = 0; a < GRID_DEPTH; a++)
            begin
                @(negedge clk);
                random_word(w);
                load_en   = 1'b1;
                load_dir  = dir_t'(d);
                load_addr = addr_t'(a);
                load_data = w;
            end
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic read_grid();
        for (int d = 0; d < NUM_DIRS; d++)
        begin
            for (int a = 0; a < GRID_DEPTH; a++)
            begin
                @(negedge clk);
                rd_en   = 1'b1;
                rd_dir  = dir_t'(d);
                rd_addr = addr_t'(a);
            end
        end
        @(negedge clk);
        rd_en = 1'b0;
        // last word compared at this edge
        @(negedge clk);
    endtask

    ////////////////////////////////////////
    // one sweep with traffic while busy
    ////////////////////////////////////////

    task automatic run_sweep();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (5) @(negedge clk);
        // second start, a load and a read, all to be ignored
        start     = 1'b1;
        load_en   = 1'b1;
        load_dir  = DIR_REST;
        load_addr = '0;
        load_data = 16'hdead;
        rd_en     = 1'b1;
        @(negedge clk);
        start   = 1'b0;
        load_en = 1'b0;
        rd_en   = 1'b0;
        while (!done)
            @(negedge clk);
    endtask

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("timeout, run still going after %0d cycles", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial
    begin
        int errors_before;
        int checks_before;
        int total_errors;
        cycle_limit = run_limit();
        arst_n      = 1'b0;
        start       = 1'b0;
        barriers    = '0;
        load_en     = 1'b0;
        load_dir    = DIR_REST;
        load_addr   = '0;
        load_data   = '0;
        rd_en       = 1'b0;
        rd_dir      = DIR_REST;
        rd_addr     = '0;
        exp_busy    = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++)
        begin
            errors_before = errors;
            checks_before = checks;
            @(negedge clk);
            barriers = test_mask[t];
            exp_busy = test_busy[t];
            load_grid();
            // loaded words back before any sweep
            read_grid();
            for (int s = 0; s < test_sweeps[t]; s++)
            begin
                run_sweep();
                read_grid();
            end
            $display("test %s sweeps %0d  checks %0d  errors %0d", test_name[t],
                     test_sweeps[t], checks - checks_before, errors - errors_before);
        end
        total_errors = errors
                       + u_lbm_stream_core.u_lbm_sweep_sequencer.u_lbm_sweep_props.assert_errors;
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, total_errors);
        if (total_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- verilog.f
source/lbm_pkg.sv
source/lbm_sweep_sequencer.sv
source/lbm_direction_lane.sv
source/lbm_readout.sv
source/lbm_stream_core.sv
tests/lbm_sweep_props.sv
tests/lbm_checker.sv
tests/lbm_tb.sv

//--- Bender.yml
package:
  name: lbm_stream_core

sources:
  - files:
      - source/lbm_pkg.sv
      - source/lbm_sweep_sequencer.sv
      - source/lbm_direction_lane.sv
      - source/lbm_readout.sv
      - source/lbm_stream_core.sv
  - target: test
    files:
      - tests/lbm_sweep_props.sv
      - tests/lbm_checker.sv
      - tests/lbm_tb.sv
